// ==== hw/blocks_pkg.sv ====
`default_nettype none

package blocks_pkg;

    typedef logic [3:0]  color_idx_t;   // Palette index, 0 = background / transparent
    typedef logic [9:0]  coord_t;       // Pixel coordinate
    typedef logic [23:0] rgb_t;         // {red, green, blue}

    // Region of a line or a frame, in scan order
    typedef enum logic [1:0] {
        ST_ACTIVE,
        ST_FRONT,
        ST_SYNC,
        ST_BACK
    } sync_state_t;

    // Fixed colour table shared by playfield and sprites
    localparam rgb_t PALETTE [16] = '{
        24'h000000,                     // Background
        24'h00f0f0,                     // Cyan
        24'h0000f0,                     // Blue
        24'hf0a000,                     // Orange
        24'hf0f000,                     // Yellow
        24'h00f000,                     // Green
        24'ha000f0,                     // Purple
        24'hf00000,                     // Red
        24'h808080,                     // Grey wall
        24'h404040,                     // Dark grey
        24'hffffff,                     // White
        24'h80c0ff,
        24'hff80c0,
        24'hc0ff80,
        24'h202060,                     // Dim navy
        24'h606020
    };

endpackage

`default_nettype wire

// ==== hw/vga_timing.sv ====
`default_nettype none

module vga_timing #(
    parameter int H_ACTIVE = 64,
    parameter int H_FP     = 4,
    parameter int H_SYNC   = 8,
    parameter int H_BP     = 4,
    parameter int V_ACTIVE = 48,
    parameter int V_FP     = 2,
    parameter int V_SYNC   = 2,
    parameter int V_BP     = 2
) (
    input  wire                 Clk,
    input  wire                 arst_n,
    output blocks_pkg::coord_t  draw_x,
    output blocks_pkg::coord_t  draw_y,
    output logic                active,
    output logic                hsync_raw,
    output logic                vsync_raw
);

    localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;

    localparam blocks_pkg::coord_t H_FP_START   = blocks_pkg::coord_t'(H_ACTIVE);
    localparam blocks_pkg::coord_t H_SYNC_START = blocks_pkg::coord_t'(H_ACTIVE + H_FP);
    localparam blocks_pkg::coord_t H_BP_START   = blocks_pkg::coord_t'(H_ACTIVE + H_FP + H_SYNC);
    localparam blocks_pkg::coord_t H_LAST       = blocks_pkg::coord_t'(H_TOTAL - 1);
    localparam blocks_pkg::coord_t V_FP_START   = blocks_pkg::coord_t'(V_ACTIVE);
    localparam blocks_pkg::coord_t V_SYNC_START = blocks_pkg::coord_t'(V_ACTIVE + V_FP);
    localparam blocks_pkg::coord_t V_BP_START   = blocks_pkg::coord_t'(V_ACTIVE + V_FP + V_SYNC);
    localparam blocks_pkg::coord_t V_LAST       = blocks_pkg::coord_t'(V_TOTAL - 1);

    blocks_pkg::sync_state_t h_state, v_state;
    blocks_pkg::coord_t      h_next, v_next;
    logic                    h_last, v_last;

    // Which region a count falls in; each axis starts with its active part
    function automatic blocks_pkg::sync_state_t region(input blocks_pkg::coord_t cnt,
                                                        input blocks_pkg::coord_t fp_start,
                                                        input blocks_pkg::coord_t sync_start,
                                                        input blocks_pkg::coord_t bp_start);
        if (cnt < fp_start)
            return blocks_pkg::ST_ACTIVE;
        if (cnt < sync_start)
            return blocks_pkg::ST_FRONT;
        if (cnt < bp_start)
            return blocks_pkg::ST_SYNC;
        return blocks_pkg::ST_BACK;
    endfunction

    assign h_last = (draw_x == H_LAST);
    assign v_last = (draw_y == V_LAST);
    assign h_next = h_last ? '0 : draw_x + blocks_pkg::coord_t'(1);
    assign v_next = !h_last ? draw_y : (v_last ? '0 : draw_y + blocks_pkg::coord_t'(1));

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            draw_x  <= '0;
            draw_y  <= '0;
            h_state <= blocks_pkg::ST_ACTIVE;
            v_state <= blocks_pkg::ST_ACTIVE;
        end else begin
            draw_x  <= h_next;
            draw_y  <= v_next;                                      // Steps once per line
            h_state <= region(h_next, H_FP_START, H_SYNC_START, H_BP_START);
            v_state <= region(v_next, V_FP_START, V_SYNC_START, V_BP_START);
        end
    end

    assign active    = (h_state == blocks_pkg::ST_ACTIVE) && (v_state == blocks_pkg::ST_ACTIVE);
    assign hsync_raw = (h_state != blocks_pkg::ST_SYNC);          // Active low
    assign vsync_raw = (v_state != blocks_pkg::ST_SYNC);

    // Visible part of the line, taken from the counter
    a_no_sync_in_active: assert property (@(posedge Clk) disable iff (!arst_n)
        (draw_x < H_FP_START) |-> hsync_raw)
        else $error("hsync_raw low during active video");

endmodule

`default_nettype wire

// ==== hw/sprite_regs.sv ====
`default_nettype none

module sprite_regs #(
    parameter int NUM_SPRITES = 4,
    parameter int SEL_W       = 2
) (
    input  wire                         Clk,
    input  wire                         arst_n,
    input  wire                         sprite_we,
    input  wire  [SEL_W-1:0]            sprite_sel,
    input  wire  blocks_pkg::coord_t    sprite_x,
    input  wire  blocks_pkg::coord_t    sprite_y,
    input  wire  blocks_pkg::color_idx_t sprite_color,
    output blocks_pkg::coord_t          spr_x     [NUM_SPRITES],
    output blocks_pkg::coord_t          spr_y     [NUM_SPRITES],
    output blocks_pkg::color_idx_t      spr_color [NUM_SPRITES]
);

    logic sel_ok;

    assign sel_ok = (int'(sprite_sel) < NUM_SPRITES);

    // One strobe loads all three fields of the selected sprite
    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_SPRITES; i++) begin
                spr_x[i]     <= '0;
                spr_y[i]     <= '0;
                spr_color[i] <= '0;                                 // Transparent
            end
        end else if (sprite_we && sel_ok) begin
            spr_x[sprite_sel]     <= sprite_x;
            spr_y[sprite_sel]     <= sprite_y;
            spr_color[sprite_sel] <= sprite_color;
        end
    end

    a_sel_in_range: assert property (@(posedge Clk) disable iff (!arst_n)
        sprite_we |-> sel_ok)
        else $error("sprite_sel %0d out of range", sprite_sel);

endmodule

`default_nettype wire

// ==== hw/block_sprite.sv ====
`default_nettype none

module block_sprite #(
    parameter int TILE_SHIFT = 3
) (
    input  wire                          Clk,
    input  wire                          arst_n,
    input  wire  blocks_pkg::coord_t     draw_x,
    input  wire  blocks_pkg::coord_t     draw_y,
    input  wire  blocks_pkg::coord_t     spr_x,
    input  wire  blocks_pkg::coord_t     spr_y,
    input  wire  blocks_pkg::color_idx_t spr_color,
    output logic                         hit,
    output blocks_pkg::color_idx_t       hit_color
);

    localparam int DW = $bits(blocks_pkg::coord_t) + 1;

    logic [DW-1:0] dx, dy;
    logic          in_x, in_y;

    // Extra top bit catches pixels left of / above the sprite
    assign dx = {1'b0, draw_x} - {1'b0, spr_x};
    assign dy = {1'b0, draw_y} - {1'b0, spr_y};

    // Inside when the offset is below one tile edge
    assign in_x = (dx[DW-1:TILE_SHIFT] == '0);
    assign in_y = (dy[DW-1:TILE_SHIFT] == '0);

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n)
            hit <= 1'b0;
        else
            hit <= in_x && in_y && (spr_color != '0);               // Colour 0 never hits
    end

    always_ff @(posedge Clk) begin
        hit_color <= spr_color;
    end

endmodule

`default_nettype wire

// ==== hw/playfield_ram.sv ====
`default_nettype none

module playfield_ram #(
    parameter int GRID_W     = 8,
    parameter int GRID_H     = 6,
    parameter int COL_W      = 3,
    parameter int ROW_W      = 3,
    parameter int TILE_SHIFT = 3
) (
    input  wire                          Clk,
    input  wire                          arst_n,
    input  wire                          tile_we,
    input  wire  [COL_W-1:0]             tile_col,
    input  wire  [ROW_W-1:0]             tile_row,
    input  wire  blocks_pkg::color_idx_t tile_color,
    input  wire  blocks_pkg::coord_t     draw_x,
    input  wire  blocks_pkg::coord_t     draw_y,
    output blocks_pkg::color_idx_t       tile_pixel
);

    localparam int IDX_W = $bits(blocks_pkg::coord_t) - TILE_SHIFT;

    blocks_pkg::color_idx_t grid [GRID_H][GRID_W];
    logic [IDX_W-1:0]       rd_col, rd_row;
    logic                   wr_ok, rd_ok;

    assign rd_col = draw_x[$bits(blocks_pkg::coord_t)-1:TILE_SHIFT];   // Pixel to tile
    assign rd_row = draw_y[$bits(blocks_pkg::coord_t)-1:TILE_SHIFT];
    assign rd_ok  = (int'(rd_col) < GRID_W) && (int'(rd_row) < GRID_H);
    assign wr_ok  = (int'(tile_col) < GRID_W) && (int'(tile_row) < GRID_H);

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < GRID_H; r++) begin
                for (int c = 0; c < GRID_W; c++)
                    grid[r][c] <= '0;
            end
            tile_pixel <= '0;
        end else begin
            if (tile_we && wr_ok)
                grid[tile_row][tile_col] <= tile_color;
            // Blanking area reads past the grid, give background there
            tile_pixel <= rd_ok ? grid[rd_row[ROW_W-1:0]][rd_col[COL_W-1:0]] : '0;
        end
    end

    a_tile_write_in_range: assert property (@(posedge Clk) disable iff (!arst_n)
        tile_we |-> wr_ok)
        else $error("tile write outside grid at col %0d row %0d", tile_col, tile_row);

endmodule

`default_nettype wire

// ==== hw/pixel_mixer.sv ====
`default_nettype none

module pixel_mixer #(
    parameter int NUM_SPRITES = 4
) (
    input  wire                          Clk,
    input  wire                          arst_n,
    input  wire                          active,
    input  wire                          hsync_raw,
    input  wire                          vsync_raw,
    input  wire  blocks_pkg::color_idx_t tile_pixel,
    input  wire                          hit       [NUM_SPRITES],
    input  wire  blocks_pkg::color_idx_t hit_color [NUM_SPRITES],
    output logic [7:0]                   red,
    output logic [7:0]                   green,
    output logic [7:0]                   blue,
    output logic                         blank_n,
    output logic                         hsync,
    output logic                         vsync
);

    logic                   active_d, hsync_d, vsync_d;
    blocks_pkg::color_idx_t pick;
    blocks_pkg::rgb_t       pick_rgb;

    // Timing goes one stage behind to meet the tile and sprite data
    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            active_d <= 1'b0;
            hsync_d  <= 1'b1;
            vsync_d  <= 1'b1;
        end else begin
            active_d <= active;
            hsync_d  <= hsync_raw;
            vsync_d  <= vsync_raw;
        end
    end

    // Walk from the last sprite down so sprite 0 ends up on top
    always_comb begin
        pick = tile_pixel;
        for (int i = NUM_SPRITES - 1; i >= 0; i--) begin
            if (hit[i])
                pick = hit_color[i];
        end
    end

    assign pick_rgb = blocks_pkg::PALETTE[pick];

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            {red, green, blue} <= '0;
            blank_n            <= 1'b0;
            hsync              <= 1'b1;
            vsync              <= 1'b1;
        end else begin
            {red, green, blue} <= active_d ? pick_rgb : '0;       // Black when blanked
            blank_n            <= active_d;
            hsync              <= hsync_d;
            vsync              <= vsync_d;
        end
    end

endmodule

`default_nettype wire

// ==== hw/block_display.sv ====
`default_nettype none

module block_display #(
    parameter  int H_ACTIVE    = 64,
    parameter  int H_FP        = 4,
    parameter  int H_SYNC      = 8,
    parameter  int H_BP        = 4,
    parameter  int V_ACTIVE    = 48,
    parameter  int V_FP        = 2,
    parameter  int V_SYNC      = 2,
    parameter  int V_BP        = 2,
    parameter  int TILE_SHIFT  = 3,
    parameter  int GRID_W      = 8,
    parameter  int GRID_H      = 6,
    parameter  int NUM_SPRITES = 4,
    localparam int SEL_W       = (NUM_SPRITES > 1) ? $clog2(NUM_SPRITES) : 1,
    localparam int COL_W       = (GRID_W > 1) ? $clog2(GRID_W) : 1,
    localparam int ROW_W       = (GRID_H > 1) ? $clog2(GRID_H) : 1
) (
    input  wire                          Clk,
    input  wire                          arst_n,
    input  wire                          tile_we,          // Host tile write strobe
    input  wire  [COL_W-1:0]             tile_col,
    input  wire  [ROW_W-1:0]             tile_row,
    input  wire  blocks_pkg::color_idx_t tile_color,
    input  wire                          sprite_we,        // Host sprite write strobe
    input  wire  [SEL_W-1:0]             sprite_sel,
    input  wire  blocks_pkg::coord_t     sprite_x,
    input  wire  blocks_pkg::coord_t     sprite_y,
    input  wire  blocks_pkg::color_idx_t sprite_color,
    output logic [7:0]                   red,
    output logic [7:0]                   green,
    output logic [7:0]                   blue,
    output logic                         blank_n,
    output logic                         hsync,
    output logic                         vsync
);

    blocks_pkg::coord_t     draw_x, draw_y;
    logic                   active, hsync_raw, vsync_raw;
    blocks_pkg::coord_t     spr_x     [NUM_SPRITES];
    blocks_pkg::coord_t     spr_y     [NUM_SPRITES];
    blocks_pkg::color_idx_t spr_color [NUM_SPRITES];
    logic                   hit       [NUM_SPRITES];
    blocks_pkg::color_idx_t hit_color [NUM_SPRITES];
    blocks_pkg::color_idx_t tile_pixel;

    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) u_timing (
        .Clk, .arst_n, .draw_x, .draw_y, .active, .hsync_raw, .vsync_raw
    );

    sprite_regs #(.NUM_SPRITES(NUM_SPRITES), .SEL_W(SEL_W)) u_sprite_regs (
        .Clk, .arst_n, .sprite_we, .sprite_sel, .sprite_x, .sprite_y, .sprite_color,
        .spr_x, .spr_y, .spr_color
    );

    for (genvar i = 0; i < NUM_SPRITES; i++) begin : g_sprite
        block_sprite #(.TILE_SHIFT(TILE_SHIFT)) u_sprite (
            .Clk, .arst_n, .draw_x, .draw_y,
            .spr_x(spr_x[i]), .spr_y(spr_y[i]), .spr_color(spr_color[i]),
            .hit(hit[i]), .hit_color(hit_color[i])
        );
    end

    playfield_ram #(
        .GRID_W(GRID_W), .GRID_H(GRID_H), .COL_W(COL_W), .ROW_W(ROW_W),
        .TILE_SHIFT(TILE_SHIFT)
    ) u_playfield (
        .Clk, .arst_n, .tile_we, .tile_col, .tile_row, .tile_color,
        .draw_x, .draw_y, .tile_pixel
    );

    pixel_mixer #(.NUM_SPRITES(NUM_SPRITES)) u_mixer (
        .Clk, .arst_n, .active, .hsync_raw, .vsync_raw, .tile_pixel, .hit, .hit_color,
        .red, .green, .blue, .blank_n, .hsync, .vsync
    );

endmodule

`default_nettype wire

// ==== tb/tb_clk_gen.sv ====
`default_nettype none

module tb_clk_gen #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 3
) (
    output logic Clk,
    output logic arst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        Clk = 1'b0;
        forever #(HALF_PERIOD) Clk = ~Clk;                          // 8 ns period
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge Clk);
        arst_n = 1'b1;                                              // Released between edges
    end

endmodule

`default_nettype wire

// ==== tb/tb_block_display.sv ====
`default_nettype none

module tb_block_display;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int H_ACTIVE = 64, H_FP = 4, H_SYNC = 8, H_BP = 4;
    localparam int V_ACTIVE = 48, V_FP = 2, V_SYNC = 2, V_BP = 2;
    localparam int TILE_SHIFT = 3, GRID_W = 8, GRID_H = 6, NUM_SPRITES = 4;
    localparam int TILE = 1 << TILE_SHIFT;
    localparam int SEL_W = $clog2(NUM_SPRITES);
    localparam int COL_W = $clog2(GRID_W);
    localparam int ROW_W = $clog2(GRID_H);
    localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int PIXELS = H_ACTIVE * V_ACTIVE;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    logic                   Clk, arst_n;
    logic                   tile_we, sprite_we;
    logic [COL_W-1:0]       tile_col;
    logic [ROW_W-1:0]       tile_row;
    blocks_pkg::color_idx_t tile_color, sprite_color;
    logic [SEL_W-1:0]       sprite_sel;
    blocks_pkg::coord_t     sprite_x, sprite_y;
    logic [7:0]             red, green, blue;
    logic                   blank_n, hsync, vsync;

    blocks_pkg::color_idx_t tile_model  [GRID_H][GRID_W];       // What the host wrote
    blocks_pkg::coord_t     spr_x_m     [NUM_SPRITES];
    blocks_pkg::coord_t     spr_y_m     [NUM_SPRITES];
    blocks_pkg::color_idx_t spr_color_m [NUM_SPRITES];
    blocks_pkg::rgb_t       frame       [PIXELS];                // Raster order
    logic [31:0]            lfsr_state = 32'hc7f582f0;
    int                     errors, pass_count, fail_count;

    tb_clk_gen #(.HALF_PERIOD(4), .RESET_CYCLES(3)) u_clk_gen (.Clk, .arst_n);

    block_display #(
        .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP),
        .TILE_SHIFT(TILE_SHIFT), .GRID_W(GRID_W), .GRID_H(GRID_H),
        .NUM_SPRITES(NUM_SPRITES)
    ) u_dut (
        .Clk, .arst_n, .tile_we, .tile_col, .tile_row, .tile_color,
        .sprite_we, .sprite_sel, .sprite_x, .sprite_y, .sprite_color,
        .red, .green, .blue, .blank_n, .hsync, .vsync
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // One LFSR step per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic blocks_pkg::color_idx_t rand_nonzero_color();
        blocks_pkg::color_idx_t c;
        c = blocks_pkg::color_idx_t'(rand_bits(4));
        return (c == 4'd0) ? 4'd1 : c;
    endfunction

    // Lowest sprite index covering the pixel wins, else the tile below
    function automatic blocks_pkg::rgb_t expected_rgb(input int x, input int y);
        blocks_pkg::color_idx_t idx;
        logic                   found;
        idx   = tile_model[y >> TILE_SHIFT][x >> TILE_SHIFT];
        found = 1'b0;
        for (int s = 0; s < NUM_SPRITES; s++) begin
            if (!found && spr_color_m[s] != 4'd0 &&
                x >= int'(spr_x_m[s]) && x < int'(spr_x_m[s]) + TILE &&
                y >= int'(spr_y_m[s]) && y < int'(spr_y_m[s]) + TILE) begin
                idx   = spr_color_m[s];
                found = 1'b1;
            end
        end
        return blocks_pkg::PALETTE[idx];
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("[ERROR] %s: expected 0x%0h, got 0x%0h", name, exp, act);
        errors++;
    endtask

    task automatic abort_run(input string why);
        $display("Timeout: %s", why);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            pass_count++;
            $display("%-14s passed", name);
        end else begin
            fail_count++;
            $display("%-14s failed with %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic write_tile(input int col, input int row, input blocks_pkg::color_idx_t c);
        @(negedge Clk);
        tile_we    = 1'b1;
        tile_col   = COL_W'(col);
        tile_row   = ROW_W'(row);
        tile_color = c;
        tile_model[row][col] = c;
        @(negedge Clk);
        tile_we = 1'b0;
    endtask

    task automatic write_sprite(input int sel, input blocks_pkg::coord_t x,
                                input blocks_pkg::coord_t y, input blocks_pkg::color_idx_t c);
        @(negedge Clk);
        sprite_we    = 1'b1;
        sprite_sel   = SEL_W'(sel);
        sprite_x     = x;
        sprite_y     = y;
        sprite_color = c;
        spr_x_m[sel]     = x;
        spr_y_m[sel]     = y;
        spr_color_m[sel] = c;
        @(negedge Clk);
        sprite_we = 1'b0;
    endtask

    task automatic wait_vsync_fall();
        logic prev, seen;
        int   n;
        seen = 1'b0;
        n    = 0;
        @(negedge Clk);
        prev = vsync;
        while (!seen && n < FRAME_CYCLES + H_TOTAL) begin
            @(negedge Clk);
            n++;
            seen = prev && !vsync;
            prev = vsync;
        end
        if (!seen)
            abort_run("no falling edge on vsync");
    endtask

    task automatic capture_frame();
        int n, guard;
        wait_vsync_fall();
        n     = 0;
        guard = 0;
        while (n < PIXELS && guard < FRAME_CYCLES) begin
            @(negedge Clk);
            guard++;
            if (blank_n) begin
                frame[n] = {red, green, blue};
                n++;
            end
        end
        if (n < PIXELS)
            abort_run("frame ended before all visible pixels arrived");
    endtask

    task automatic compare_frame(input string what);
        blocks_pkg::rgb_t exp;
        int               bad;
        bad = 0;
        for (int y = 0; y < V_ACTIVE; y++) begin
            for (int x = 0; x < H_ACTIVE; x++) begin
                exp = expected_rgb(x, y);
                if (frame[y * H_ACTIVE + x] !== exp) begin
                    if (bad < 8)
                        $display("[ERROR] {red,green,blue} at x=%0d y=%0d: expected 0x%06h, got 0x%06h",
                                 x, y, exp, frame[y * H_ACTIVE + x]);
                    bad++;
                end
            end
        end
        if (bad > 0)
            $display("%s: %0d pixels differ from the model", what, bad);
        errors += bad;
    endtask

    task automatic test_reset_values();
        int errs0, n;
        errs0 = errors;
        n     = 0;
        while (arst_n !== 1'b1 && n < 20) begin
            @(negedge Clk);
            n++;
        end
        if (arst_n !== 1'b1)
            abort_run("reset never released");
        if (hsync !== 1'b1)
            report_mismatch("hsync", 32'h1, 32'(hsync));
        if (vsync !== 1'b1)
            report_mismatch("vsync", 32'h1, 32'(vsync));
        if (blank_n !== 1'b0)
            report_mismatch("blank_n", 32'h0, 32'(blank_n));
        if ({red, green, blue} !== 24'h0)
            report_mismatch("{red,green,blue}", 32'h0, 32'({red, green, blue}));
        finish_test("reset", errs0);
    endtask

    // Two frames of sync and blanking measured sample by sample
    task automatic test_geometry();
        int   errs0, cyc, last_hfall, hlow, vlow, hfalls, brun, lines, frames;
        logic ph, pv, pb;
        errs0 = errors;
        // White block reaching into both the right and the bottom blanking
        write_sprite(0, blocks_pkg::coord_t'(H_ACTIVE - TILE / 2),
                     blocks_pkg::coord_t'(V_ACTIVE - TILE / 2), 4'd10);
        wait_vsync_fall();
        ph = hsync;
        pv = vsync;
        pb = blank_n;
        last_hfall = -1;
        hlow = 0;
        vlow = 1;                                                   // Current sample is low
        hfalls = 0;
        brun = 0;
        lines = 0;
        frames = 0;
        for (cyc = 1; cyc <= 2 * FRAME_CYCLES; cyc++) begin
            @(negedge Clk);
            if (ph && !hsync) begin
                if (last_hfall >= 0 && cyc - last_hfall != H_TOTAL)
                    report_mismatch("hsync period", H_TOTAL, cyc - last_hfall);
                last_hfall = cyc;
                hlow = 0;
                hfalls++;
            end
            if (!hsync)
                hlow++;
            if (!ph && hsync && last_hfall >= 0 && hlow != H_SYNC)
                report_mismatch("hsync low width", H_SYNC, hlow);
            if (pv && !vsync) begin
                if (hfalls != V_TOTAL)
                    report_mismatch("vsync period in lines", V_TOTAL, hfalls);
                if (lines != V_ACTIVE)
                    report_mismatch("visible lines per frame", V_ACTIVE, lines);
                frames++;
                hfalls = 0;
                lines = 0;
                vlow = 0;
            end
            if (!vsync)
                vlow++;
            if (!pv && vsync && vlow != V_SYNC * H_TOTAL)
                report_mismatch("vsync low cycles", V_SYNC * H_TOTAL, vlow);
            if (blank_n)
                brun++;
            if (pb && !blank_n) begin
                if (brun != H_ACTIVE)
                    report_mismatch("visible pixels per line", H_ACTIVE, brun);
                lines++;
                brun = 0;
            end
            if (!blank_n && {red, green, blue} !== 24'h0)
                report_mismatch("{red,green,blue} while blanked", 32'h0, 32'({red, green, blue}));
            ph = hsync;
            pv = vsync;
            pb = blank_n;
        end
        if (frames != 2)
            report_mismatch("frames measured", 2, frames);
        write_sprite(0, '0, '0, 4'd0);
        finish_test("geometry", errs0);
    endtask

    task automatic test_playfield();
        int errs0;
        errs0 = errors;
        for (int r = 0; r < GRID_H; r++) begin
            for (int c = 0; c < GRID_W; c++)
                write_tile(c, r, blocks_pkg::color_idx_t'(rand_bits(4)));
        end
        capture_frame();
        compare_frame("playfield");
        finish_test("playfield", errs0);
    endtask

    // Overlapping pair plus one sprite hanging off each of right and bottom
    task automatic test_sprites();
        int                 errs0;
        blocks_pkg::coord_t x0, y0;
        errs0 = errors;
        x0 = blocks_pkg::coord_t'(rand_bits(6));
        y0 = blocks_pkg::coord_t'(rand_bits(6) % V_ACTIVE);
        write_sprite(0, x0, y0, rand_nonzero_color());
        write_sprite(1, blocks_pkg::coord_t'(int'(x0) + 3 + int'(rand_bits(2))),
                     blocks_pkg::coord_t'(int'(y0) + 2 + int'(rand_bits(2))), rand_nonzero_color());
        write_sprite(2, blocks_pkg::coord_t'(H_ACTIVE - 1 - int'(rand_bits(2))),
                     blocks_pkg::coord_t'(rand_bits(6) % V_ACTIVE), rand_nonzero_color());
        write_sprite(3, blocks_pkg::coord_t'(rand_bits(6)),
                     blocks_pkg::coord_t'(V_ACTIVE - 2 - int'(rand_bits(2))), rand_nonzero_color());
        capture_frame();
        compare_frame("sprites");
        finish_test("sprites", errs0);
    endtask

    task automatic test_transparency();
        int errs0;
        errs0 = errors;
        write_sprite(1, spr_x_m[1], spr_y_m[1], 4'd0);              // Tiles must show through
        capture_frame();
        compare_frame("transparent");
        write_sprite(2, blocks_pkg::coord_t'(rand_bits(6) % (H_ACTIVE - TILE)),
                     blocks_pkg::coord_t'(rand_bits(6) % (V_ACTIVE - TILE)), spr_color_m[2]);
        capture_frame();
        compare_frame("moved");
        finish_test("transparency", errs0);
    endtask

    initial begin
        tile_we      = 1'b0;
        tile_col     = '0;
        tile_row     = '0;
        tile_color   = '0;
        sprite_we    = 1'b0;
        sprite_sel   = '0;
        sprite_x     = '0;
        sprite_y     = '0;
        sprite_color = '0;
        errors       = 0;
        pass_count   = 0;
        fail_count   = 0;
        for (int r = 0; r < GRID_H; r++) begin
            for (int c = 0; c < GRID_W; c++)
                tile_model[r][c] = '0;
        end
        for (int s = 0; s < NUM_SPRITES; s++) begin
            spr_x_m[s]     = '0;
            spr_y_m[s]     = '0;
            spr_color_m[s] = '0;
        end

        test_reset_values();
        test_geometry();
        test_playfield();
        test_sprites();
        test_transparency();

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
hw/blocks_pkg.sv
hw/vga_timing.sv
hw/sprite_regs.sv
hw/block_sprite.sv
hw/playfield_ram.sv
hw/pixel_mixer.sv
hw/block_display.sv
tb/tb_clk_gen.sv
tb/tb_block_display.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --timing --assert --timescale 1ns/100ps
TOP       := tb_block_display
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := *** TEST PASSED ***
FAIL_MSG  := *** TEST FAILED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG) || ! grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
